// File: design/achk_decode.sv
`timescale 1ns/1ps
`default_nettype none

// Rebuilds the protection fields of one port from its request fields
// The fetch port has no write fields, so it uses a reduced form of the checksum
module achk_decode #(
  parameter bit HAS_WDATA = 1'b1
) (
  input  wire bus_chk_pkg::bus_req_t req_i,
  output bus_chk_pkg::req_exp_t      exp_o
);

  logic [3:0]         addr_par;
  logic [3:0]         wdata_par;
  logic               attr_par;
  logic               be_par;
  logic               dbg_par;
  bus_chk_pkg::achk_t achk;

  ////////////////////////////////////////
  // Fields common to both ports
  ////////////////////////////////////////

  // Even parity of each address byte lands in bits 3 to 0
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      addr_par[i] = ^req_i.addr[8*i +: 8];
    end
  end

  // Odd parity over prot and memtype
  assign attr_par = ~^{req_i.prot, req_i.memtype};

  // Odd parity of the debug flag alone
  assign dbg_par = ~^req_i.dbg;

  ////////////////////////////////////////
  // Write related fields
  ////////////////////////////////////////

  if (HAS_WDATA) begin : g_data
    // Odd parity over the byte enables and the write flag
    assign be_par = ~^{req_i.be, req_i.we};

    // Even parity of each write data byte lands in bits 11 to 8
    always_comb begin
      for (int i = 0; i < 4; i++) begin
        wdata_par[i] = ^req_i.wdata[8*i +: 8];
      end
    end
  end else begin : g_fetch
    // A fetch behaves like four set enables with we clear
    // which gives odd parity 1
    assign be_par = 1'b1;

    // No write data on the fetch port
    assign wdata_par = 4'b0000;
  end

  ////////////////////////////////////////
  // Checksum assembly
  ////////////////////////////////////////

  // Bit 7 is reserved and always zero
  assign achk = {wdata_par, 1'b0, dbg_par, be_par, attr_par, addr_par};

  // The request parity is the plain inverse of req, in idle cycles too
  assign exp_o = '{achk: achk, reqpar: ~req_i.req};

endmodule

`default_nettype wire

// File: design/bus_chk_cfg.svh
`ifndef BUS_CHK_CFG_SVH
`define BUS_CHK_CFG_SVH

////////////////////////////////////////
// Observed memory bus
////////////////////////////////////////

// Address and write data width of both core ports
`define BUS_AW 32
`define BUS_DW 32

// Address phase checksum carried next to each request
`define ACHK_W 12

////////////////////////////////////////
// Monitor register file
////////////////////////////////////////

// Width of each per-port saturating error counter
`define CNT_W 16

// APB byte address width, enough for four word registers
`define APB_AW 4

// Register offsets within the APB window
`define REG_STATUS 4'h0
`define REG_ICNT   4'h4
`define REG_DCNT   4'h8
`define REG_MASK   4'hC

`endif

// File: design/bus_chk_pkg.sv
`default_nettype none

`include "bus_chk_cfg.svh"

package bus_chk_pkg;

  // Address phase fields of the core memory ports
  typedef logic [`BUS_AW-1:0] addr_t;
  typedef logic [`BUS_DW-1:0] data_t;
  typedef logic [`ACHK_W-1:0] achk_t;

  // Bit 0 of the memory type marks a bufferable access
  typedef logic [1:0] memtype_t;
  typedef logic [2:0] prot_t;
  typedef logic [3:0] be_t;

  // Saturating violation counter
  typedef logic [`CNT_W-1:0] cnt_t;

  // One bit per rule, ordered as in err_idx_e
  typedef logic [6:0] err_vec_t;

  // Bit positions inside err_vec_t
  // Instruction port rules sit in the low nibble
  typedef enum logic [2:0] {
    ERR_I_ACHK  = 3'd0,
    ERR_I_PAR   = 3'd1,
    ERR_I_ALIGN = 3'd2,
    ERR_I_BUF   = 3'd3,
    ERR_D_ACHK  = 3'd4,
    ERR_D_PAR   = 3'd5,
    ERR_D_BUF   = 3'd6
  } err_idx_e;

  // Request side of one port as seen on the bus
  typedef struct packed {
    logic     req;
    logic     reqpar;
    logic     we;
    be_t      be;
    addr_t    addr;
    achk_t    achk;
    memtype_t memtype;
    prot_t    prot;
    logic     dbg;
    data_t    wdata;
  } bus_req_t;

  // Protection values the monitor derives from a request
  typedef struct packed {
    achk_t achk;
    logic  reqpar;
  } req_exp_t;

  // APB slave side, data is as wide as the bus data
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [`APB_AW-1:0] paddr;
    data_t             pwdata;
  } apb_req_t;

  typedef struct packed {
    data_t prdata;
    logic  pready;
    logic  pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// File: design/bus_integrity_monitor.sv
`timescale 1ns/1ps
`default_nettype none

// Passive integrity monitor for the fetch and data request ports of the core
// It never drives the observed bus, software reads results over APB
module bus_integrity_monitor (
  input  wire logic                  clk,
  input  wire logic                  rst_ni,
  input  wire bus_chk_pkg::bus_req_t instr_req_i,
  input  wire bus_chk_pkg::bus_req_t data_req_i,
  input  wire bus_chk_pkg::apb_req_t apb_i,
  output bus_chk_pkg::apb_rsp_t      apb_o,
  output logic                       alert_o
);

  bus_chk_pkg::req_exp_t instr_exp;
  bus_chk_pkg::req_exp_t data_exp;
  bus_chk_pkg::err_vec_t err;

  ////////////////////////////////////////
  // Expected protection fields
  ////////////////////////////////////////

  // Fetch port uses the checksum form without write fields
  achk_decode #(
    .HAS_WDATA (1'b0)
  ) u_instr_dec (
    .req_i (instr_req_i),
    .exp_o (instr_exp)
  );

  achk_decode #(
    .HAS_WDATA (1'b1)
  ) u_data_dec (
    .req_i (data_req_i),
    .exp_o (data_exp)
  );

  ////////////////////////////////////////
  // Rule check and reporting
  ////////////////////////////////////////

  // Errors leave here one cycle after the offending request
  req_rule_exec u_exec (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .instr_req_i (instr_req_i),
    .data_req_i  (data_req_i),
    .instr_exp_i (instr_exp),
    .data_exp_i  (data_exp),
    .err_o       (err)
  );

  // Status becomes visible one cycle later again
  integrity_status u_status (
    .clk     (clk),
    .rst_ni  (rst_ni),
    .err_i   (err),
    .apb_i   (apb_i),
    .apb_o   (apb_o),
    .alert_o (alert_o)
  );

endmodule

`default_nettype wire

// File: design/integrity_status.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_chk_cfg.svh"

// Sticky violation status, per-port counters and alert mask behind an APB slave
module integrity_status (
  input  wire logic                  clk,
  input  wire logic                  rst_ni,
  input  wire bus_chk_pkg::err_vec_t err_i,
  input  wire bus_chk_pkg::apb_req_t apb_i,
  output bus_chk_pkg::apb_rsp_t      apb_o,
  output logic                       alert_o
);

  logic                  apb_access;
  logic                  apb_wr;
  logic                  sel_status;
  logic                  sel_icnt;
  logic                  sel_dcnt;
  logic                  sel_mask;
  logic                  mapped;
  logic                  inc_icnt;
  logic                  inc_dcnt;
  bus_chk_pkg::err_vec_t clr_bits;
  bus_chk_pkg::err_vec_t status_q;
  bus_chk_pkg::err_vec_t mask_q;
  bus_chk_pkg::cnt_t     icnt_q;
  bus_chk_pkg::cnt_t     dcnt_q;
  bus_chk_pkg::data_t    prdata;

  // Next counter value, a clear is overridden by a new error
  function automatic bus_chk_pkg::cnt_t cnt_next(input bus_chk_pkg::cnt_t cnt,
                                                 input logic clr,
                                                 input logic inc);
    bus_chk_pkg::cnt_t base;
    base = clr ? '0 : cnt;
    // Hold at the top value instead of wrapping
    if (inc && (base != '1)) begin
      return base + bus_chk_pkg::cnt_t'(1);
    end
    return base;
  endfunction

  ////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////

  // No wait states, so every access phase completes the transfer
  assign apb_access = apb_i.psel & apb_i.penable;
  assign apb_wr     = apb_access & apb_i.pwrite;

  always_comb begin
    sel_status = 1'b0;
    sel_icnt   = 1'b0;
    sel_dcnt   = 1'b0;
    sel_mask   = 1'b0;
    case (apb_i.paddr)
      `REG_STATUS: sel_status = 1'b1;
      `REG_ICNT:   sel_icnt   = 1'b1;
      `REG_DCNT:   sel_dcnt   = 1'b1;
      `REG_MASK:   sel_mask   = 1'b1;
      default: ;
    endcase
  end

  assign mapped = sel_status | sel_icnt | sel_dcnt | sel_mask;

  ////////////////////////////////////////
  // Status and counters
  ////////////////////////////////////////

  // Ones written to STATUS clear those bits
  assign clr_bits = (apb_wr && sel_status) ? bus_chk_pkg::err_vec_t'(apb_i.pwdata) : '0;

  // A counter steps once per cycle with any violation on its port
  assign inc_icnt = err_i[bus_chk_pkg::ERR_I_ACHK] | err_i[bus_chk_pkg::ERR_I_PAR] |
                    err_i[bus_chk_pkg::ERR_I_ALIGN] | err_i[bus_chk_pkg::ERR_I_BUF];
  assign inc_dcnt = err_i[bus_chk_pkg::ERR_D_ACHK] | err_i[bus_chk_pkg::ERR_D_PAR] |
                    err_i[bus_chk_pkg::ERR_D_BUF];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      status_q <= '0;
      icnt_q   <= '0;
      dcnt_q   <= '0;
      mask_q   <= '1;
    end else begin
      // New violations are ORed in after the clear so they are never lost
      status_q <= (status_q & ~clr_bits) | err_i;
      icnt_q   <= cnt_next(icnt_q, apb_wr && sel_icnt, inc_icnt);
      dcnt_q   <= cnt_next(dcnt_q, apb_wr && sel_dcnt, inc_dcnt);
      if (apb_wr && sel_mask) begin
        mask_q <= bus_chk_pkg::err_vec_t'(apb_i.pwdata);
      end
    end
  end

  ////////////////////////////////////////
  // Read path and alert
  ////////////////////////////////////////

  // Read data is only driven during a read access phase
  always_comb begin
    prdata = '0;
    if (apb_access && !apb_i.pwrite) begin
      if (sel_status) begin
        prdata = bus_chk_pkg::data_t'(status_q);
      end else if (sel_icnt) begin
        prdata = bus_chk_pkg::data_t'(icnt_q);
      end else if (sel_dcnt) begin
        prdata = bus_chk_pkg::data_t'(dcnt_q);
      end else if (sel_mask) begin
        prdata = bus_chk_pkg::data_t'(mask_q);
      end
    end
  end

  // Unmapped offsets are flagged in the access phase only
  assign apb_o = '{prdata: prdata, pready: 1'b1, pslverr: apb_access & ~mapped};

  // Any unmasked sticky bit raises the alert
  assign alert_o = |(status_q & mask_q);

endmodule

`default_nettype wire

// File: design/req_rule_exec.sv
`timescale 1ns/1ps
`default_nettype none

// Applies the bus protection and attribute rules to both ports
// The result is flopped once and holds for a single cycle
module req_rule_exec (
  input  wire logic                  clk,
  input  wire logic                  rst_ni,
  input  wire bus_chk_pkg::bus_req_t instr_req_i,
  input  wire bus_chk_pkg::bus_req_t data_req_i,
  input  wire bus_chk_pkg::req_exp_t instr_exp_i,
  input  wire bus_chk_pkg::req_exp_t data_exp_i,
  output bus_chk_pkg::err_vec_t      err_o
);

  logic                  instr_act;
  logic                  data_act;
  logic                  data_load;
  bus_chk_pkg::err_vec_t err_d;
  bus_chk_pkg::err_vec_t err_q;

  // Qualifiers for the rules that only apply to live requests
  assign instr_act = instr_req_i.req;
  assign data_act  = data_req_i.req;
  assign data_load = data_req_i.req & ~data_req_i.we;

  ////////////////////////////////////////
  // Instruction port rules
  ////////////////////////////////////////

  always_comb begin
    err_d = '0;

    // Checksum only means something while a fetch is on the bus
    err_d[bus_chk_pkg::ERR_I_ACHK] = instr_act &&
                                     (instr_req_i.achk != instr_exp_i.achk);

    // Parity also covers the idle level of req
    err_d[bus_chk_pkg::ERR_I_PAR] = instr_req_i.reqpar != instr_exp_i.reqpar;

    // Fetches are always whole words
    err_d[bus_chk_pkg::ERR_I_ALIGN] = instr_act && (instr_req_i.addr[1:0] != 2'b00);

    // Fetches must never be bufferable
    err_d[bus_chk_pkg::ERR_I_BUF] = instr_act && instr_req_i.memtype[0];

    ////////////////////////////////////////
    // Data port rules
    ////////////////////////////////////////

    err_d[bus_chk_pkg::ERR_D_ACHK] = data_act &&
                                     (data_req_i.achk != data_exp_i.achk);

    err_d[bus_chk_pkg::ERR_D_PAR] = data_req_i.reqpar != data_exp_i.reqpar;

    // Stores may be bufferable, only loads are checked
    err_d[bus_chk_pkg::ERR_D_BUF] = data_load && data_req_i.memtype[0];
  end

  // Capture the violations at the edge that samples the request
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      err_q <= '0;
    end else begin
      err_q <= err_d;
    end
  end

  assign err_o = err_q;

endmodule

`default_nettype wire

// File: sim/bus_integrity_monitor_props.sv
`timescale 1ns/1ps
`default_nettype none

// Watches the APB slave and the alert path from inside integrity_status
module bus_integrity_monitor_props (
  input wire logic                  clk,
  input wire logic                  rst_ni,
  input wire bus_chk_pkg::apb_req_t apb_i,
  input wire bus_chk_pkg::apb_rsp_t apb_o,
  input wire logic                  alert_o,
  input wire bus_chk_pkg::err_vec_t err_i,
  input wire bus_chk_pkg::err_vec_t mask_q
);

  logic access;
  int   fail_cnt = 0;

  // Second phase of a transfer with psel and penable both high
  assign access = apb_i.psel && apb_i.penable;

  ////////////////////////////////////////
  // APB protocol
  ////////////////////////////////////////

  // The slave never inserts wait states
  a_ready_in_access: assert property (@(posedge clk) disable iff (!rst_ni)
    access |-> apb_o.pready)
    else begin
      $error("pready was low during an APB access phase");
      fail_cnt++;
    end

  // A new access phase always follows a setup phase
  a_setup_first: assert property (@(posedge clk) disable iff (!rst_ni)
    (access && !$past(access)) |-> $past(apb_i.psel && !apb_i.penable))
    else begin
      $error("APB access phase without a preceding setup phase");
      fail_cnt++;
    end

  // Slave errors only show up while a transfer completes
  a_slverr_in_access: assert property (@(posedge clk) disable iff (!rst_ni)
    !access |-> !apb_o.pslverr)
    else begin
      $error("pslverr raised outside an APB access phase");
      fail_cnt++;
    end

  ////////////////////////////////////////
  // Alert
  ////////////////////////////////////////

  // An unmasked violation raises the alert one edge later unless the mask moves
  a_alert_on_error: assert property (@(posedge clk) disable iff (!rst_ni)
    |(err_i & mask_q) |=> (alert_o || (mask_q != $past(mask_q))))
    else begin
      $error("alert_o stayed low after an unmasked violation");
      fail_cnt++;
    end

endmodule

bind integrity_status bus_integrity_monitor_props u_props (
  .clk      (clk),
  .rst_ni   (rst_ni),
  .apb_i    (apb_i),
  .apb_o    (apb_o),
  .alert_o  (alert_o),
  .err_i    (err_i),
  .mask_q   (mask_q)
);

`default_nettype wire

// File: sim/bus_integrity_monitor_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bus_chk_cfg.svh"

module bus_integrity_monitor_tb;

  localparam int NUM_ENTRIES = 10;
  localparam int APB_TIMEOUT = 20;

  typedef enum int {
    CORR_NONE, CORR_ACHK, CORR_PAR, CORR_ALIGN, CORR_BUF_FETCH, CORR_BUF_LOAD, CORR_BUF_STORE
  } corr_e;

  typedef struct {
    corr_e                 corr_i;
    corr_e                 corr_d;
    bus_chk_pkg::err_vec_t exp_status;
  } entry_t;

  logic                  clk;
  logic                  rst_ni;
  bus_chk_pkg::bus_req_t instr_req;
  bus_chk_pkg::bus_req_t data_req;
  bus_chk_pkg::apb_req_t apb_req;
  bus_chk_pkg::apb_rsp_t apb_rsp;
  logic                  alert;
  int                    err_cnt;
  int                    check_cnt;
  int                    icnt_mdl;
  int                    dcnt_mdl;
  bus_chk_pkg::err_vec_t mdl_err;

  // Port corruption per entry and the STATUS it must leave behind
  entry_t vec_tbl [NUM_ENTRIES] = '{
    '{CORR_NONE,      CORR_NONE,      7'h00},
    '{CORR_NONE,      CORR_NONE,      7'h00},
    '{CORR_ACHK,      CORR_NONE,      7'h01},
    '{CORR_PAR,       CORR_NONE,      7'h02},
    '{CORR_ALIGN,     CORR_NONE,      7'h04},
    '{CORR_BUF_FETCH, CORR_NONE,      7'h08},
    '{CORR_NONE,      CORR_ACHK,      7'h10},
    '{CORR_NONE,      CORR_PAR,       7'h20},
    '{CORR_NONE,      CORR_BUF_LOAD,  7'h40},
    '{CORR_NONE,      CORR_BUF_STORE, 7'h00}
  };

  bus_integrity_monitor DUT (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .instr_req_i (instr_req),
    .data_req_i  (data_req),
    .apb_i       (apb_req),
    .apb_o       (apb_rsp),
    .alert_o     (alert)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Checksum built straight from the bus rule
  // Fetches have no write fields
  function automatic bus_chk_pkg::achk_t calc_achk(input bus_chk_pkg::bus_req_t r,
                                                  input bit fetch);
    bus_chk_pkg::achk_t c;
    c = '0;
    for (int b = 0; b < 4; b++) begin
      c[b] = ^r.addr[8*b +: 8];
      c[8+b] = fetch ? 1'b0 : ^r.wdata[8*b +: 8];
    end
    c[4] = !(^{r.prot, r.memtype});
    c[5] = fetch ? 1'b1 : !(^{r.be, r.we});
    c[6] = !r.dbg;
    return c;
  endfunction

  function automatic bus_chk_pkg::err_vec_t rule_errors(input bus_chk_pkg::bus_req_t i,
                                                        input bus_chk_pkg::bus_req_t d);
    bus_chk_pkg::err_vec_t e;
    e = '0;
    // Parity must invert req whether or not a request is live
    e[bus_chk_pkg::ERR_I_PAR] = (i.reqpar == i.req);
    e[bus_chk_pkg::ERR_D_PAR] = (d.reqpar == d.req);
    if (i.req) begin
      e[bus_chk_pkg::ERR_I_ACHK]  = (i.achk != calc_achk(i, 1'b1));
      e[bus_chk_pkg::ERR_I_ALIGN] = (i.addr[1:0] != 2'b00);
      e[bus_chk_pkg::ERR_I_BUF]   = i.memtype[0];
    end
    if (d.req) begin
      e[bus_chk_pkg::ERR_D_ACHK] = (d.achk != calc_achk(d, 1'b0));
      e[bus_chk_pkg::ERR_D_BUF]  = !d.we && d.memtype[0];
    end
    return e;
  endfunction

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  function automatic bus_chk_pkg::bus_req_t idle_req();
    bus_chk_pkg::bus_req_t r;
    r = '0;
    r.reqpar = 1'b1;
    return r;
  endfunction

  // Builds a random legal request and then breaks one field
  function automatic bus_chk_pkg::bus_req_t build_req(input bit fetch, input corr_e corr);
    bus_chk_pkg::bus_req_t r;
    int                    flip_bit;
    r = '0;
    r.req = 1'b1;
    r.addr = $urandom();
    r.prot = 3'($urandom());
    r.memtype = {1'($urandom()), 1'b0};
    r.dbg = 1'($urandom());
    if (fetch) begin
      r.addr[1:0] = 2'b00;
      r.be = 4'hF;
    end else begin
      r.we = 1'($urandom());
      r.be = 4'($urandom());
      r.wdata = $urandom();
    end
    case (corr)
      CORR_ALIGN: r.addr[1:0] = 2'(1 + $urandom_range(2));
      CORR_BUF_FETCH, CORR_BUF_LOAD: begin
        r.memtype[0] = 1'b1;
        r.we = 1'b0;
      end
      CORR_BUF_STORE: begin
        r.memtype[0] = 1'b1;
        r.we = 1'b1;
      end
      default: ;
    endcase
    r.achk = calc_achk(r, fetch);
    if (corr == CORR_ACHK) begin
      flip_bit = $urandom_range(11);
      r.achk[flip_bit] = ~r.achk[flip_bit];
    end
    if (corr == CORR_PAR) begin
      r.reqpar = 1'b1;
    end
    return r;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("[ERROR] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // Drives one request pair for a single cycle and then idles with correct parity
  task automatic run_pair(input corr_e ci, input corr_e cd);
    bus_chk_pkg::bus_req_t ireq;
    bus_chk_pkg::bus_req_t dreq;
    ireq = build_req(1'b1, ci);
    dreq = build_req(1'b0, cd);
    mdl_err = rule_errors(ireq, dreq);
    icnt_mdl += (|mdl_err[3:0]) ? 1 : 0;
    dcnt_mdl += (|mdl_err[6:4]) ? 1 : 0;
    @(posedge clk);
    instr_req <= ireq;
    data_req  <= dreq;
    @(posedge clk);
    instr_req <= idle_req();
    data_req  <= idle_req();
    repeat (3) @(posedge clk);
  endtask

  ////////////////////////////////////////
  // APB master
  ////////////////////////////////////////

  task automatic apb_xfer(input logic wr, input logic [`APB_AW-1:0] addr,
                          input bus_chk_pkg::data_t wdata,
                          output bus_chk_pkg::data_t rdata, output logic slverr);
    int waits;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    waits = 0;
    @(negedge clk);
    while (!apb_rsp.pready && waits < APB_TIMEOUT) begin
      @(negedge clk);
      waits++;
    end
    if (!apb_rsp.pready) begin
      $display("APB transfer at offset 0x%0h saw no pready within %0d cycles", addr, waits);
      err_cnt++;
    end
    rdata  = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    // The transfer completes on this edge
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic reg_read(input logic [`APB_AW-1:0] addr, input string name,
                          input logic [31:0] exp);
    bus_chk_pkg::data_t rd;
    logic               slverr;
    apb_xfer(1'b0, addr, '0, rd, slverr);
    check_val(name, rd, exp);
    check_val({name, " pslverr"}, slverr, 32'd0);
  endtask

  task automatic reg_write(input logic [`APB_AW-1:0] addr, input bus_chk_pkg::data_t data);
    bus_chk_pkg::data_t rd;
    logic               slverr;
    apb_xfer(1'b1, addr, data, rd, slverr);
    check_val("pslverr", slverr, 32'd0);
  endtask

  task automatic check_alert(input logic exp);
    @(negedge clk);
    check_val("alert_o", alert, exp);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    bus_chk_pkg::data_t rd;
    logic               slverr;
    int                 assert_fails;
    void'($urandom(32'he465_5311));
    err_cnt   = 0;
    check_cnt = 0;
    icnt_mdl  = 0;
    dcnt_mdl  = 0;
    rst_ni    = 1'b0;
    instr_req = idle_req();
    data_req  = idle_req();
    apb_req   = '0;
    repeat (16) @(posedge clk);
    rst_ni <= 1'b1;

    // Reset values
    check_alert(1'b0);
    reg_read(`REG_MASK, "MASK", 32'h7F);
    reg_read(`REG_STATUS, "STATUS", 32'h0);

    // Each entry is checked on its own and STATUS is cleared after it
    for (int n = 0; n < NUM_ENTRIES; n++) begin
      run_pair(vec_tbl[n].corr_i, vec_tbl[n].corr_d);
      check_val("reference error vector", mdl_err, vec_tbl[n].exp_status);
      reg_read(`REG_STATUS, "STATUS", vec_tbl[n].exp_status);
      reg_read(`REG_ICNT, "ICNT", icnt_mdl);
      reg_read(`REG_DCNT, "DCNT", dcnt_mdl);
      check_alert(|vec_tbl[n].exp_status);
      reg_write(`REG_STATUS, 32'h7F);
      check_alert(1'b0);
      reg_read(`REG_STATUS, "STATUS", 32'h0);
    end

    // Both ports fail at once and the bits are cleared one at a time
    run_pair(CORR_ALIGN, CORR_BUF_LOAD);
    reg_read(`REG_STATUS, "STATUS", 32'h44);
    reg_write(`REG_STATUS, 32'h04);
    reg_read(`REG_STATUS, "STATUS", 32'h40);
    check_alert(1'b1);

    // Masking drops the alert but STATUS keeps its bits
    reg_write(`REG_MASK, 32'h0);
    check_alert(1'b0);
    reg_read(`REG_STATUS, "STATUS", 32'h40);
    reg_write(`REG_MASK, 32'h7F);
    check_alert(1'b1);
    reg_write(`REG_STATUS, 32'h40);
    check_alert(1'b0);

    // Any write zeroes a counter and leaves the other port untouched
    reg_write(`REG_ICNT, 32'h0);
    icnt_mdl = 0;
    reg_read(`REG_ICNT, "ICNT", icnt_mdl);
    reg_read(`REG_DCNT, "DCNT", dcnt_mdl);
    reg_write(`REG_DCNT, 32'h1234);
    reg_read(`REG_DCNT, "DCNT", 32'h0);

    // Unmapped offsets answer with a slave error and change nothing
    apb_xfer(1'b0, 4'h6, '0, rd, slverr);
    check_val("pslverr", slverr, 32'd1);
    apb_xfer(1'b1, 4'hE, '0, rd, slverr);
    check_val("pslverr", slverr, 32'd1);
    reg_read(`REG_MASK, "MASK", 32'h7F);

    // Failed concurrent assertions count against the run as well
    assert_fails = DUT.u_status.u_props.fail_cnt;
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             check_cnt, err_cnt, assert_fails);
    if (err_cnt == 0 && assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/bus_chk_pkg.sv
design/achk_decode.sv
design/req_rule_exec.sv
design/integrity_status.sv
design/bus_integrity_monitor.sv
sim/bus_integrity_monitor_props.sv
sim/bus_integrity_monitor_tb.sv
